//--- src/fetch_pkg.sv
// Command encodings must match the instruction cache and the decode stage of this pipeline
package fetch_pkg;

    ////////////////////
    // Data types
    ////////////////////

    // Byte address of an instruction word
    typedef logic [31:0] addr_t;

    // One instruction word as returned by the cache
    typedef logic [31:0] instr_t;

    // Cache response status, forwarded to decode untouched
    typedef logic [3:0] status_t;

    // Command presented on the cache request port
    typedef logic [3:0] cache_cmd_t;

    // Command sent from decode back to fetch
    typedef logic [1:0] d2f_cmd_t;

    // Kind of item handed to decode
    typedef logic f2d_type_t;

    ////////////////////
    // Encodings
    ////////////////////

    // The cache treats any other value as a reserved command
    localparam cache_cmd_t CACHE_CMD_NONE      = 4'h0;
    localparam cache_cmd_t CACHE_CMD_EXECUTE   = 4'h1;
    localparam cache_cmd_t CACHE_CMD_FLUSH_ALL = 4'h4;

    // Decode holds D2F_CMD_NONE whenever it has nothing to redirect
    localparam d2f_cmd_t D2F_CMD_NONE         = 2'd0;
    localparam d2f_cmd_t D2F_CMD_START_BRANCH = 2'd1;
    localparam d2f_cmd_t D2F_CMD_FLUSH        = 2'd2;

    localparam f2d_type_t F2D_TYPE_INSTR             = 1'b0;
    localparam f2d_type_t F2D_TYPE_INTERRUPT_PENDING = 1'b1;

    // Sequential fetches step one 32-bit word at a time
    localparam addr_t INSTR_STEP = 32'd4;

endpackage

//--- src/fetch_redirect.sv
// Assumes decode sends at most one redirect per fetch and only while d2f_ready is high
module fetch_redirect
    import fetch_pkg::*;
#(
    parameter addr_t RESET_VECTOR = 32'h0000_1000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       d2f_ready,
    input  d2f_cmd_t   d2f_cmd,
    input  addr_t      d2f_branchtarget,
    input  logic       capture_en,
    input  logic       req_fire,
    input  cache_cmd_t req_cmd,
    output logic       branch_pending,
    output logic       branching,
    output logic       flushing,
    output addr_t      redirect_target
);

    // A flush always carries a branch to its restart address as well
    logic  flush_pending;
    addr_t target_q;

    // Commands from decode only count while decode is ready
    logic  arriving_branch;
    logic  arriving_flush;
    logic  arriving_any;

    ////////////////////
    // Live view
    ////////////////////

    assign arriving_branch = d2f_ready && (d2f_cmd == D2F_CMD_START_BRANCH);
    assign arriving_flush  = d2f_ready && (d2f_cmd == D2F_CMD_FLUSH);
    assign arriving_any    = arriving_branch || arriving_flush;

    // The request logic sees both the stored command and the one arriving now
    assign branching = branch_pending || arriving_branch;
    assign flushing  = flush_pending || arriving_flush;

    // A branch arriving this cycle overrides an older stored target
    assign redirect_target = arriving_branch ? d2f_branchtarget : target_q;

    ////////////////////
    // Stored redirect
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Leaving reset looks like a branch to the reset vector
            branch_pending <= 1'b1;
            flush_pending  <= 1'b0;
            target_q       <= RESET_VECTOR;
        end else if (req_fire && (req_cmd == CACHE_CMD_FLUSH_ALL)) begin
            flush_pending <= 1'b0;
            // A flush taken straight from decode still needs its restart branch
            if (arriving_any) begin
                branch_pending <= 1'b1;
                target_q       <= d2f_branchtarget;
            end
        end else if (req_fire && (req_cmd == CACHE_CMD_EXECUTE) && branching) begin
            // The cache accepted the fetch at the redirect target
            branch_pending <= 1'b0;
        end else if (capture_en && arriving_any) begin
            // Command could not steer this cycle so keep it for the next decision
            branch_pending <= 1'b1;
            flush_pending  <= flush_pending || arriving_flush;
            target_q       <= d2f_branchtarget;
        end
    end

endmodule

//--- src/fetch_request.sv
// Issues one cache request at a time and starts fetching one cycle after rst_n is released
module fetch_request
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_ready,
    input  logic       resp_valid,
    input  logic       d2f_ready,
    input  logic       interrupt_pending,
    input  logic       held_valid,
    input  logic       branch_pending,
    input  logic       branching,
    input  logic       flushing,
    input  addr_t      redirect_target,
    output logic       req_valid,
    output cache_cmd_t req_cmd,
    output addr_t      req_address,
    output logic       req_fire,
    output logic       capture_en,
    output logic       resp_is_instr,
    output addr_t      pc
);

    // Low through reset and for the first cycle after it
    logic       running;

    // Set while the cache owes a response for an accepted request
    logic       outstanding;

    // Command of the request that is outstanding
    cache_cmd_t last_cmd;

    // The response of this cycle leaves fetch and frees the slot
    logic       resp_done;

    // A new request may be presented in this cycle
    logic       start;

    ////////////////////
    // Slot tracking
    ////////////////////

    // Only an executed fetch produces something for decode
    assign resp_is_instr = outstanding && (last_cmd == CACHE_CMD_EXECUTE);

    // Flush responses and instructions killed by a branch need no decode handshake
    assign resp_done = resp_valid && outstanding &&
                       (!resp_is_instr || branch_pending || d2f_ready);

    // Idle slot or a slot that empties right now
    assign start = running &&
                   ((!held_valid && !outstanding) ||
                    resp_done ||
                    (held_valid && d2f_ready));

    ////////////////////
    // Command choice
    ////////////////////

    always_comb begin
        req_cmd     = CACHE_CMD_NONE;
        req_address = pc;
        if (start && !interrupt_pending) begin
            if (flushing) begin
                // Flush first because the restart branch follows it
                req_cmd = CACHE_CMD_FLUSH_ALL;
            end else if (branching) begin
                req_cmd     = CACHE_CMD_EXECUTE;
                req_address = redirect_target;
            end else begin
                req_cmd     = CACHE_CMD_EXECUTE;
                req_address = pc + INSTR_STEP;
            end
        end
    end

    assign req_valid = (req_cmd != CACHE_CMD_NONE);
    assign req_fire  = req_valid && req_ready;

    // Any command that did not ride on an accepted request has to be stored
    assign capture_en = outstanding || !req_fire;

    ////////////////////
    // State
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running     <= 1'b0;
            outstanding <= 1'b0;
            last_cmd    <= CACHE_CMD_NONE;
        end else begin
            running <= 1'b1;
            // A new acceptance wins over the response of the previous request
            if (req_fire) begin
                outstanding <= 1'b1;
                last_cmd    <= req_cmd;
            end else if (resp_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

    // The PC follows every accepted address
    // A flush is sent at the current PC so it leaves the PC alone
    always_ff @(posedge clk) begin
        if (req_fire) begin
            pc <= req_address;
        end
    end

endmodule

//--- src/fetch_response_buffer.sv
// Holds a single response and relies on the request block to stop fetching while it is full
module fetch_response_buffer
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      resp_valid,
    input  logic      resp_is_instr,
    input  status_t   resp_status,
    input  instr_t    resp_read_data,
    input  addr_t     pc,
    input  logic      d2f_ready,
    input  logic      branch_pending,
    input  logic      interrupt_pending,
    output logic      held_valid,
    output logic      f2d_valid,
    output f2d_type_t f2d_type,
    output instr_t    f2d_instr,
    output addr_t     f2d_pc,
    output status_t   f2d_status
);

    // Copy of a response that decode did not take in its cycle
    instr_t  held_instr;
    status_t held_status;

    // Instruction response arriving from the cache right now
    logic    live_instr;

    assign live_instr = resp_valid && resp_is_instr;

    ////////////////////
    // Decode side
    ////////////////////

    always_comb begin
        f2d_valid  = 1'b0;
        f2d_type   = F2D_TYPE_INSTR;
        f2d_instr  = resp_read_data;
        f2d_pc     = pc;
        f2d_status = resp_status;
        if (held_valid) begin
            // Older data goes first and vanishes if a branch overtook it
            f2d_valid  = !branch_pending;
            f2d_instr  = held_instr;
            f2d_status = held_status;
        end else if (live_instr) begin
            f2d_valid = !branch_pending;
        end else if (rst_n && !resp_is_instr && interrupt_pending) begin
            // No instruction owed so decode can start the interrupt
            f2d_valid  = 1'b1;
            f2d_type   = F2D_TYPE_INTERRUPT_PENDING;
            f2d_instr  = '0;
            f2d_status = '0;
        end
    end

    ////////////////////
    // Hold register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (held_valid) begin
            // Released on acceptance or dropped by a pending branch
            if (d2f_ready || branch_pending) begin
                held_valid <= 1'b0;
            end
        end else if (live_instr && !branch_pending && !d2f_ready) begin
            held_valid <= 1'b1;
        end
    end

    // PC needs no copy since no request goes out while an item is held
    always_ff @(posedge clk) begin
        if (live_instr && !held_valid) begin
            held_instr  <= resp_read_data;
            held_status <= resp_status;
        end
    end

endmodule

//--- src/fetch_top.sv
// Assumes one single-cycle cache response per accepted request and no response back-pressure
module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t RESET_VECTOR = 32'h0000_1000
) (
    input  logic       clk,
    input  logic       rst_n,

    // Cache request
    output logic       req_valid,
    output cache_cmd_t req_cmd,
    output addr_t      req_address,
    input  logic       req_ready,

    // Cache response
    input  logic       resp_valid,
    input  status_t    resp_status,
    input  instr_t     resp_read_data,

    input  logic       interrupt_pending,

    // Items towards decode
    output logic       f2d_valid,
    output f2d_type_t  f2d_type,
    output instr_t     f2d_instr,
    output addr_t      f2d_pc,
    output status_t    f2d_status,

    // Commands from decode
    input  logic       d2f_ready,
    input  d2f_cmd_t   d2f_cmd,
    input  addr_t      d2f_branchtarget
);

    // Redirect state steering the request logic
    logic  branch_pending;
    logic  branching;
    logic  flushing;
    addr_t redirect_target;

    // Request handshake feedback to the redirect block
    logic  capture_en;
    logic  req_fire;

    // Response path towards the buffer
    logic  resp_is_instr;
    addr_t pc;
    logic  held_valid;

    fetch_redirect #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_redirect (
        .clk              (clk),
        .rst_n            (rst_n),
        .d2f_ready        (d2f_ready),
        .d2f_cmd          (d2f_cmd),
        .d2f_branchtarget (d2f_branchtarget),
        .capture_en       (capture_en),
        .req_fire         (req_fire),
        .req_cmd          (req_cmd),
        .branch_pending   (branch_pending),
        .branching        (branching),
        .flushing         (flushing),
        .redirect_target  (redirect_target)
    );

    fetch_request u_request (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_ready         (req_ready),
        .resp_valid        (resp_valid),
        .d2f_ready         (d2f_ready),
        .interrupt_pending (interrupt_pending),
        .held_valid        (held_valid),
        .branch_pending    (branch_pending),
        .branching         (branching),
        .flushing          (flushing),
        .redirect_target   (redirect_target),
        .req_valid         (req_valid),
        .req_cmd           (req_cmd),
        .req_address       (req_address),
        .req_fire          (req_fire),
        .capture_en        (capture_en),
        .resp_is_instr     (resp_is_instr),
        .pc                (pc)
    );

    fetch_response_buffer u_buffer (
        .clk               (clk),
        .rst_n             (rst_n),
        .resp_valid        (resp_valid),
        .resp_is_instr     (resp_is_instr),
        .resp_status       (resp_status),
        .resp_read_data    (resp_read_data),
        .pc                (pc),
        .d2f_ready         (d2f_ready),
        .branch_pending    (branch_pending),
        .interrupt_pending (interrupt_pending),
        .held_valid        (held_valid),
        .f2d_valid         (f2d_valid),
        .f2d_type          (f2d_type),
        .f2d_instr         (f2d_instr),
        .f2d_pc            (f2d_pc),
        .f2d_status        (f2d_status)
    );

endmodule

//--- dv/fetch_cache_model.sv
// Serves one request at a time and answers every accepted request, FLUSH_ALL included
module fetch_cache_model
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  cache_cmd_t req_cmd,
    input  addr_t      req_address,
    output logic       req_ready,
    output logic       resp_valid,
    output status_t    resp_status,
    output instr_t     resp_read_data
);

    logic [31:0] lfsr = 32'h10c4_99a2;

    // Request being served and cycles left until its response
    logic        busy;
    int          wait_cnt;
    int          latency;
    addr_t       addr_q;
    logic        flush_q;
    logic        fire;
    logic        next_ready;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    initial begin
        busy           = 1'b0;
        wait_cnt       = 0;
        flush_q        = 1'b0;
        addr_q         = '0;
        req_ready      = 1'b0;
        resp_valid     = 1'b0;
        resp_status    = '0;
        resp_read_data = '0;
        forever begin
            @(posedge clk);
            fire       = 1'b0;
            next_ready = 1'b0;
            if (!rst_n) begin
                busy = 1'b0;
            end else begin
                if (busy) begin
                    wait_cnt--;
                    if (wait_cnt == 0) begin
                        fire = 1'b1;
                        busy = 1'b0;
                    end
                end
                if (req_valid && req_ready) begin
                    // Latency of 1 to 3 cycles counted from the acceptance cycle
                    latency = 1 + (random_bits(2) % 3);
                    addr_q  = req_address;
                    flush_q = (req_cmd == CACHE_CMD_FLUSH_ALL);
                    if (latency == 1) begin
                        fire = 1'b1;
                    end else begin
                        busy     = 1'b1;
                        wait_cnt = latency - 1;
                    end
                end
                // Ready three cycles out of four on average
                next_ready = (random_bits(2) != 0);
            end
            #2;
            resp_valid = fire;
            if (fire) begin
                resp_read_data = flush_q ? '0 : (addr_q ^ 32'h5a5a_0000);
                resp_status    = flush_q ? '0 : addr_q[5:2];
            end
            req_ready = next_ready;
        end
    end

endmodule

//--- dv/fetch_sva.sv
// Checks the request encoding, decode-side holding and reset quiet outputs of fetch_top
module fetch_sva
    import fetch_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      req_valid,
    input cache_cmd_t req_cmd,
    input logic      f2d_valid,
    input f2d_type_t f2d_type,
    input instr_t    f2d_instr,
    input addr_t     f2d_pc,
    input status_t   f2d_status,
    input logic      d2f_ready
);

    // Number of assertion failures so far
    int fail_count = 0;

    // The valid bit is only a summary of the command field
    req_valid_matches_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid == (req_cmd != CACHE_CMD_NONE))
        else begin
            $error("req_valid disagrees with req_cmd");
            fail_count++;
        end

    // An instruction that decode stalls on must come back unchanged
    stalled_instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (f2d_valid && (f2d_type == F2D_TYPE_INSTR) && !d2f_ready) |=>
        (f2d_valid && $stable(f2d_type) && $stable(f2d_instr) &&
         $stable(f2d_pc) && $stable(f2d_status)))
        else begin
            $error("stalled f2d item changed before decode took it");
            fail_count++;
        end

    reset_f2d_quiet: assert property (@(posedge clk) !rst_n |-> !f2d_valid)
        else begin
            $error("f2d_valid high during reset");
            fail_count++;
        end

endmodule

bind fetch_top fetch_sva sva0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_cmd    (req_cmd),
    .f2d_valid  (f2d_valid),
    .f2d_type   (f2d_type),
    .f2d_instr  (f2d_instr),
    .f2d_pc     (f2d_pc),
    .f2d_status (f2d_status),
    .d2f_ready  (d2f_ready)
);

//--- dv/fetch_tb.sv
// Redirect targets in the table must be word aligned and no redirect is sent while an interrupt is up
module fetch_tb
    import fetch_pkg::*;
();

    localparam addr_t RESET_VECTOR = 32'h0000_1000;

    // One test: length, stall density out of 4, optional redirect and interrupt level
    typedef struct {
        string    name;
        int       cycles;
        int       stall;
        d2f_cmd_t cmd;
        addr_t    target;
        int       issue;
        logic     irq;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    cache_cmd_t req_cmd;
    addr_t      req_address;
    logic       req_ready;
    logic       resp_valid;
    status_t    resp_status;
    instr_t     resp_read_data;
    logic       interrupt_pending;
    logic       f2d_valid;
    f2d_type_t  f2d_type;
    instr_t     f2d_instr;
    addr_t      f2d_pc;
    status_t    f2d_status;
    logic       d2f_ready;
    d2f_cmd_t   d2f_cmd;
    addr_t      d2f_branchtarget;

    row_t        rows[$];
    logic [31:0] lfsr = 32'h10c4_99a2;

    // Scoreboard state
    addr_t exp_pc      = RESET_VECTOR;
    logic  first_seen  = 1'b0;
    logic  flush_due   = 1'b0;
    logic  awaiting    = 1'b0;
    int    instr_seen  = 0;
    int    irq_seen    = 0;
    int    checks      = 0;
    int    errors      = 0;
    int    failed      = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    fetch_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_valid         (req_valid),
        .req_cmd           (req_cmd),
        .req_address       (req_address),
        .req_ready         (req_ready),
        .resp_valid        (resp_valid),
        .resp_status       (resp_status),
        .resp_read_data    (resp_read_data),
        .interrupt_pending (interrupt_pending),
        .f2d_valid         (f2d_valid),
        .f2d_type          (f2d_type),
        .f2d_instr         (f2d_instr),
        .f2d_pc            (f2d_pc),
        .f2d_status        (f2d_status),
        .d2f_ready         (d2f_ready),
        .d2f_cmd           (d2f_cmd),
        .d2f_branchtarget  (d2f_branchtarget)
    );

    fetch_cache_model cache0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_cmd        (req_cmd),
        .req_address    (req_address),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_status    (resp_status),
        .resp_read_data (resp_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_that(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("** Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input int cycles, input int stall,
                           input d2f_cmd_t cmd, input addr_t target, input int issue,
                           input logic irq);
        row_t r;
        r.name   = name;
        r.cycles = cycles;
        r.stall  = stall;
        r.cmd    = cmd;
        r.target = target;
        r.issue  = issue;
        r.irq    = irq;
        rows.push_back(r);
    endtask

    ////////////////////
    // Decode model
    ////////////////////

    task automatic run_row(input int idx);
        row_t r;
        int   err0;
        int   instr0;
        int   irq0;
        r      = rows[idx];
        err0   = errors;
        instr0 = instr_seen;
        irq0   = irq_seen;
        for (int c = 0; c < r.cycles; c++) begin
            @(posedge clk);
            #2;
            if ((c == r.issue) && (r.cmd != D2F_CMD_NONE)) begin
                // A command only counts while decode is ready
                d2f_ready        = 1'b1;
                d2f_cmd          = r.cmd;
                d2f_branchtarget = r.target;
            end else begin
                d2f_ready        = (random_bits(2) >= r.stall);
                d2f_cmd          = D2F_CMD_NONE;
                d2f_branchtarget = '0;
            end
            interrupt_pending = r.irq;
        end
        if (r.irq) begin
            check_that(irq_seen > irq0, "no interrupt-pending item reached decode");
        end else begin
            check_that(instr_seen > instr0, "no instruction was consumed in the test");
        end
        check_that(!flush_due, "the flush command never led to an accepted FLUSH_ALL");
        check_that(first_seen, "no request was accepted after reset");
        if (errors != err0) begin
            failed++;
        end
        $display("test %0d %s %s, instructions %0d, interrupt items %0d", idx, r.name,
                 (errors == err0) ? "passed" : "failed",
                 instr_seen - instr0, irq_seen - irq0);
    endtask

    ////////////////////
    // Scoreboard
    ////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            // Consumption first since a command in this cycle only steers later items
            if (f2d_valid && d2f_ready) begin
                if (f2d_type == F2D_TYPE_INSTR) begin
                    instr_seen++;
                    check_that(f2d_pc == exp_pc,
                               $sformatf("consumed pc %h, expected %h", f2d_pc, exp_pc));
                    check_that(f2d_instr == (f2d_pc ^ 32'h5a5a_0000),
                               $sformatf("instr %h at pc %h", f2d_instr, f2d_pc));
                    check_that(f2d_status == f2d_pc[5:2],
                               $sformatf("status %h at pc %h", f2d_status, f2d_pc));
                    // Sequential words are 4 bytes apart
                    exp_pc = exp_pc + 32'd4;
                end else begin
                    irq_seen++;
                end
            end
            if (d2f_ready && (d2f_cmd != D2F_CMD_NONE)) begin
                exp_pc = d2f_branchtarget;
                if (d2f_cmd == D2F_CMD_FLUSH) begin
                    flush_due = 1'b1;
                end
            end
            if (req_valid && req_ready) begin
                if (!first_seen) begin
                    first_seen = 1'b1;
                    check_that((req_cmd == CACHE_CMD_EXECUTE) && (req_address == RESET_VECTOR),
                               $sformatf("first request cmd %h addr %h", req_cmd, req_address));
                end
                if (flush_due) begin
                    check_that(req_cmd == CACHE_CMD_FLUSH_ALL,
                               $sformatf("cmd %h accepted before the FLUSH_ALL", req_cmd));
                    flush_due = 1'b0;
                end
            end
            // Nothing owed to decode, so only the interrupt item may be shown
            if (interrupt_pending && !awaiting && !resp_valid &&
                !(f2d_valid && (f2d_type == F2D_TYPE_INSTR))) begin
                check_that(!req_valid && f2d_valid && (f2d_type == F2D_TYPE_INTERRUPT_PENDING),
                           $sformatf("interrupt: req_valid %b f2d_valid %b type %b",
                                     req_valid, f2d_valid, f2d_type));
            end
            if (req_valid && req_ready) begin
                awaiting = 1'b1;
            end else if (resp_valid) begin
                awaiting = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst_n             = 1'b0;
        // Interrupt raised through reset, decode must still see nothing
        interrupt_pending = 1'b1;
        d2f_ready         = 1'b0;
        d2f_cmd           = D2F_CMD_NONE;
        d2f_branchtarget  = '0;
        add_row("sequential",   60, 0, D2F_CMD_NONE,         32'h0,         0, 1'b0);
        add_row("stalls",      120, 2, D2F_CMD_NONE,         32'h0,         0, 1'b0);
        add_row("branch",       80, 1, D2F_CMD_START_BRANCH, 32'h0000_3000, 20, 1'b0);
        add_row("flush",        80, 1, D2F_CMD_FLUSH,        32'h0000_0400, 25, 1'b0);
        add_row("interrupt",    60, 1, D2F_CMD_NONE,         32'h0,         0, 1'b1);
        add_row("resume",       60, 2, D2F_CMD_NONE,         32'h0,         0, 1'b0);
        add_row("branch_stall", 80, 3, D2F_CMD_START_BRANCH, 32'h0000_8ab0, 10, 1'b0);
        cycle_limit = 200;
        foreach (rows[i]) begin
            cycle_limit += rows[i].cycles;
        end
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(i);
        end
        @(posedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 rows.size(), failed, checks, errors, dut0.sva0.fail_count);
        if ((errors == 0) && (dut0.sva0.fail_count == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- project.f
src/fetch_pkg.sv
src/fetch_redirect.sv
src/fetch_request.sv
src/fetch_response_buffer.sv
src/fetch_top.sv
dv/fetch_cache_model.sv
dv/fetch_sva.sv
dv/fetch_tb.sv
